// File: line_buf_pkg.sv
package line_buf_pkg;

// Ring geometry.
localparam int NUM_SLICES  = 8;
localparam int IDX_W       = 3;

// Line geometry.
localparam int LINE_PIXELS = 32;
localparam int COL_W       = 5;

localparam int SEQ_W       = 7;  // Wraps after 127.
localparam int PIX_W       = 24; // Three 8-bit RGB channels.

// Input pixel as it arrives from the source.
typedef struct packed {
    logic [PIX_W-1:0] data;
    logic             sof;
} pix_in_t;

// Per-line metadata kept beside each slice RAM.
typedef struct packed {
    logic [SEQ_W-1:0] seq;
    logic             sof;
} line_meta_t;

// Output pixel with its line flags.
typedef struct packed {
    logic [PIX_W-1:0] data;
    logic             sof;
    logic             eol;
    logic [SEQ_W-1:0] seq;
} pix_out_t;

typedef enum logic {
    RD_IDLE,
    RD_LINE
} rd_state_t;

endpackage

// File: line_slice.sv
`timescale 1ns/1ps

module line_slice
    import line_buf_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             wr_en,
    input  logic [COL_W-1:0] wr_col,
    input  logic [PIX_W-1:0] wr_data,
    input  logic [COL_W-1:0] rd_col,
    output logic [PIX_W-1:0] q,
    input  logic             meta_load,
    input  line_meta_t       meta_in,
    output line_meta_t       meta
);

logic [PIX_W-1:0] mem [LINE_PIXELS];

// One line of pixels with write and read both on the rising edge.
always_ff @(posedge clk) begin
    if (wr_en) begin
        mem[wr_col] <= wr_data;
    end
    q <= mem[rd_col]; // Registered read.
end

// Sequence number and start-of-frame of the line held here.
always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        meta <= '0;
    end else if (meta_load) begin
        meta <= meta_in;
    end
end

endmodule

// File: line_writer.sv
`timescale 1ns/1ps

module line_writer
    import line_buf_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             pix_valid,
    input  pix_in_t          pix_in,
    input  logic [IDX_W-1:0] rd_idx,
    output logic [IDX_W-1:0] wr_idx,
    output logic [COL_W-1:0] wr_col,
    output logic [PIX_W-1:0] wr_data,
    output logic             commit,
    output line_meta_t       commit_meta,
    output logic             drop
);

logic             sof_q;
logic [SEQ_W-1:0] seq_q;
logic             full;
logic             line_end;

assign wr_data = pix_in.data;

// The slice under write is never readable, so 7 lines fill the ring.
assign full = (wr_idx + IDX_W'(1)) == rd_idx;

assign line_end = pix_valid && (wr_col == COL_W'(LINE_PIXELS - 1));
assign commit   = line_end && !full;
assign drop     = line_end && full; // Slice stays and takes the next line.

assign commit_meta.seq = seq_q;
assign commit_meta.sof = sof_q;

// Column counter that wraps to 0 after the last pixel of a line.
always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        wr_col <= '0;
    end else if (pix_valid) begin
        wr_col <= wr_col + COL_W'(1);
    end
end

// Start-of-frame is taken from the first pixel only.
always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        sof_q <= 1'b0;
    end else if (pix_valid && (wr_col == '0)) begin
        sof_q <= pix_in.sof;
    end
end

// Dropped lines consume neither a slice nor a sequence number.
always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        wr_idx <= '0;
        seq_q  <= '0;
    end else if (commit) begin
        wr_idx <= wr_idx + IDX_W'(1);
        seq_q  <= seq_q + SEQ_W'(1); // 127 rolls over to 0.
    end
end

endmodule

// File: line_reader.sv
`timescale 1ns/1ps

module line_reader
    import line_buf_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             rd_en,
    input  logic [IDX_W-1:0] wr_idx,
    output logic [IDX_W-1:0] rd_idx,
    output logic [COL_W-1:0] rd_col,
    input  logic [PIX_W-1:0] slice_q [NUM_SLICES],
    input  line_meta_t       slice_meta [NUM_SLICES],
    output logic             out_valid,
    output pix_out_t         pix_out
);

rd_state_t        state;
logic             ring_empty;
logic             issue;
logic             last_col;
logic [IDX_W-1:0] rd_idx_inc;

// Tag of the read in flight.
logic             tag_valid;
logic [IDX_W-1:0] tag_idx;
logic [COL_W-1:0] tag_col;
line_meta_t       sel_meta;

assign ring_empty = wr_idx == rd_idx;
assign rd_idx_inc = rd_idx + IDX_W'(1);
assign issue      = (state == RD_LINE) && rd_en; // rd_en low holds the column.
assign last_col   = rd_col == COL_W'(LINE_PIXELS - 1);

always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        state  <= RD_IDLE;
        rd_idx <= '0;
        rd_col <= '0;
    end else begin
        case (state)
            RD_IDLE: begin
                if (!ring_empty) begin
                    state  <= RD_LINE;
                    rd_col <= '0;
                end
            end
            RD_LINE: begin
                if (issue) begin
                    rd_col <= rd_col + COL_W'(1);
                    if (last_col) begin
                        // Release the slice back to the writer.
                        rd_idx <= rd_idx_inc;
                        if (wr_idx == rd_idx_inc) begin
                            state <= RD_IDLE;
                        end
                    end
                end
            end
            default: state <= RD_IDLE;
        endcase
    end
end

// Slice index and column follow the registered RAM read by one cycle.
always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
        tag_valid <= 1'b0;
        tag_idx   <= '0;
        tag_col   <= '0;
    end else begin
        tag_valid <= issue;
        tag_idx   <= rd_idx;
        tag_col   <= rd_col;
    end
end

assign sel_meta  = slice_meta[tag_idx];
assign out_valid = tag_valid;

always_comb begin
    pix_out.data = slice_q[tag_idx];
    pix_out.sof  = tag_valid && (tag_col == '0) && sel_meta.sof;
    pix_out.eol  = tag_valid && (tag_col == COL_W'(LINE_PIXELS - 1));
    pix_out.seq  = sel_meta.seq;
end

endmodule

// File: line_buffer_top.sv
`timescale 1ns/1ps

module line_buffer_top
    import line_buf_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     pix_valid,
    input  pix_in_t  pix_in,
    input  logic     rd_en,
    output logic     out_valid,
    output pix_out_t pix_out,
    output logic     drop
);

logic [IDX_W-1:0]      wr_idx;
logic [IDX_W-1:0]      rd_idx;
logic [COL_W-1:0]      wr_col;
logic [COL_W-1:0]      rd_col;
logic [PIX_W-1:0]      wr_data;
logic                  commit;
line_meta_t            commit_meta;
logic [NUM_SLICES-1:0] slice_wr_en;
logic [NUM_SLICES-1:0] slice_meta_load;
logic [PIX_W-1:0]      slice_q [NUM_SLICES];
line_meta_t            slice_meta [NUM_SLICES];

line_writer line_writer_i (
    .clk         (clk),
    .nrst        (nrst),
    .pix_valid   (pix_valid),
    .pix_in      (pix_in),
    .rd_idx      (rd_idx),
    .wr_idx      (wr_idx),
    .wr_col      (wr_col),
    .wr_data     (wr_data),
    .commit      (commit),
    .commit_meta (commit_meta),
    .drop        (drop)
);

for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
    // Only the slice under write sees pixels and the commit.
    assign slice_wr_en[i]     = pix_valid && (wr_idx == IDX_W'(i));
    assign slice_meta_load[i] = commit && (wr_idx == IDX_W'(i));

    line_slice line_slice_i (
        .clk       (clk),
        .nrst      (nrst),
        .wr_en     (slice_wr_en[i]),
        .wr_col    (wr_col),
        .wr_data   (wr_data),
        .rd_col    (rd_col),
        .q         (slice_q[i]),
        .meta_load (slice_meta_load[i]),
        .meta_in   (commit_meta),
        .meta      (slice_meta[i])
    );
end

line_reader line_reader_i (
    .clk        (clk),
    .nrst       (nrst),
    .rd_en      (rd_en),
    .wr_idx     (wr_idx),
    .rd_idx     (rd_idx),
    .rd_col     (rd_col),
    .slice_q    (slice_q),
    .slice_meta (slice_meta),
    .out_valid  (out_valid),
    .pix_out    (pix_out)
);

endmodule

// File: tb_line_buffer.sv
`timescale 1ns/1ps

module tb_line_buffer
    import line_buf_pkg::*;
();

localparam int CLK_PERIOD   = 100;
localparam int STREAM_LINES = 20;
localparam int PAUSE_LINES  = 20;
localparam int OVF_LINES    = 9;
localparam int WRAP_LINES   = 130;
localparam int LAT_LINES    = 3;
localparam int TOTAL_PIXELS = (STREAM_LINES + PAUSE_LINES + OVF_LINES + WRAP_LINES + LAT_LINES)
                              * LINE_PIXELS;
localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 4 + 1000;

typedef enum {
    RD_ON,
    RD_RANDOM,
    RD_OFF
} rd_mode_t;

logic     clk;
logic     nrst;
logic     pix_valid;
pix_in_t  pix_in;
logic     rd_en;
logic     out_valid;
pix_out_t pix_out;
logic     drop;

logic [31:0] lfsr;
pix_out_t    exp_q [$]; // Expected output pixels in arrival order.
int          commits;   // Committed lines so far set the sequence number.
logic        exp_drop;
rd_mode_t    rd_mode;
logic        gaps_on;
string       test_name;
int          cyc;
int          out_count;
int          line_start_cyc;

line_buffer_top line_buffer_top_i (
    .clk       (clk),
    .nrst      (nrst),
    .pix_valid (pix_valid),
    .pix_in    (pix_in),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .pix_out   (pix_out),
    .drop      (drop)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

always @(posedge clk) begin
    cyc <= cyc + 1; // Edge count.
end

// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1.
function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], rand_bit()};
    end
    return v;
endfunction

// Lines not yet fully read out including a partly read one.
function automatic int pending_lines();
    return (exp_q.size() + LINE_PIXELS - 1) / LINE_PIXELS;
endfunction

task automatic check_pixel(input pix_out_t exp_pix, input pix_out_t act_pix);
    if (act_pix !== exp_pix) begin
        $display("ERR %s pixel %0d: expected %h actual %h",
                 test_name, out_count, exp_pix, act_pix);
        $display("  expected data=%h sof=%b eol=%b seq=%0d",
                 exp_pix.data, exp_pix.sof, exp_pix.eol, exp_pix.seq);
        $display("  actual   data=%h sof=%b eol=%b seq=%0d",
                 act_pix.data, act_pix.sof, act_pix.eol, act_pix.seq);
        $display("Simulation failed");
        $fatal(1, "Output pixel mismatch");
    end
endtask

task automatic check_drop(input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
        $display("ERR %s drop: expected %b actual %b", test_name, exp_val, act_val);
        $display("Simulation failed");
        $fatal(1, "Drop pulse mismatch");
    end
endtask

task automatic check_latency(input int exp_val, input int act_val);
    if (act_val !== exp_val) begin
        $display("ERR %s latency: expected %0d actual %0d", test_name, exp_val, act_val);
        $display("Simulation failed");
        $fatal(1, "Commit to output latency mismatch");
    end
endtask

// One clock cycle of input applied on the falling edge.
task automatic drive_cycle(input logic valid, input pix_in_t pix, input logic drop_exp);
    @(negedge clk);
    pix_valid = valid;
    pix_in    = pix;
    exp_drop  = drop_exp;
    case (rd_mode)
        RD_ON:     rd_en = 1'b1;
        RD_RANDOM: rd_en = (rand_bits(2) != 32'd0); // High 3 cycles in 4.
        default:   rd_en = 1'b0;
    endcase
endtask

task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, 1'b0);
endtask

// Keeps the ring below full in phases that expect no drop.
task automatic wait_ring_room();
    while (pending_lines() > NUM_SLICES - 3) begin
        drive_cycle(1'b0, '0, 1'b0);
    end
endtask

task automatic wait_drained();
    while (exp_q.size() != 0) begin
        drive_cycle(1'b0, '0, 1'b0);
    end
    idle_cycles(4); // Anything extra shows up as an unexpected pixel.
endtask

// Sends one line and returns the edge that takes its last pixel.
task automatic send_line(output int commit_edge);
    pix_in_t     pix;
    pix_out_t    exp_line [LINE_PIXELS];
    logic        first_sof;
    logic        full;
    logic [31:0] bits;
    first_sof = 1'b0;
    full      = 1'b0;
    for (int col = 0; col < LINE_PIXELS; col++) begin
        while (gaps_on && (rand_bits(2) == 32'd3)) begin
            drive_cycle(1'b0, '0, 1'b0);
        end
        bits     = rand_bits(PIX_W + 1);
        pix.data = bits[PIX_W:1];
        pix.sof  = bits[0]; // Ignored past column 0.
        if (col == 0) begin
            first_sof = pix.sof;
        end
        exp_line[col].data = pix.data;
        exp_line[col].sof  = 1'b0;
        exp_line[col].eol  = (col == LINE_PIXELS - 1);
        exp_line[col].seq  = '0;
        if (col == LINE_PIXELS - 1) begin
            // Seven lines waiting leave no free slice.
            full = (pending_lines() == NUM_SLICES - 1);
        end
        drive_cycle(1'b1, pix, full && (col == LINE_PIXELS - 1));
    end
    commit_edge = cyc + 1;
    if (!full) begin
        exp_line[0].sof = first_sof;
        for (int col = 0; col < LINE_PIXELS; col++) begin
            exp_line[col].seq = SEQ_W'(commits % (2 ** SEQ_W));
            exp_q.push_back(exp_line[col]);
        end
        commits++;
    end
endtask

// Output monitor that samples late in the cycle when all outputs have settled.
initial begin
    pix_out_t exp_pix;
    forever begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        check_drop(exp_drop, drop);
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Simulation failed");
                $fatal(1, "Unexpected output pixel in %s while no line is pending",
                       test_name);
            end else begin
                if (out_count % LINE_PIXELS == 0) begin
                    line_start_cyc = cyc;
                end
                exp_pix = exp_q.pop_front();
                check_pixel(exp_pix, pix_out);
                out_count++;
            end
        end else if (out_valid !== 1'b0) begin
            $display("Simulation failed");
            $fatal(1, "out_valid is unknown in %s", test_name);
        end
    end
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Simulation failed");
    $fatal(1, "Timeout in %s: the run took longer than its test length allows", test_name);
end

initial begin
    int edge_cyc;
    lfsr           = 32'h838a;
    nrst           = 1'b0;
    pix_valid      = 1'b0;
    pix_in         = '0;
    rd_en          = 1'b0;
    exp_drop       = 1'b0;
    rd_mode        = RD_ON;
    gaps_on        = 1'b0;
    commits        = 0;
    out_count      = 0;
    line_start_cyc = 0;
    edge_cyc       = 0;
    test_name      = "reset";
    repeat (5) @(negedge clk);
    nrst = 1'b1;

    test_name = "idle";
    idle_cycles(20);

    test_name = "stream";
    gaps_on   = 1'b1;
    repeat (STREAM_LINES) begin
        wait_ring_room();
        send_line(edge_cyc);
    end
    wait_drained();

    test_name = "pause";
    rd_mode   = RD_RANDOM;
    repeat (PAUSE_LINES) begin
        wait_ring_room();
        send_line(edge_cyc);
    end
    wait_drained();

    // Nothing is released while rd_en is low, so lines 8 and 9 find the ring full.
    test_name = "overflow";
    rd_mode   = RD_OFF;
    repeat (OVF_LINES) begin
        send_line(edge_cyc);
    end
    idle_cycles(10);
    rd_mode = RD_ON;
    wait_drained();

    test_name = "seq_wrap";
    repeat (WRAP_LINES) begin
        wait_ring_room();
        send_line(edge_cyc);
    end
    wait_drained();

    test_name = "latency";
    gaps_on   = 1'b0;
    repeat (LAT_LINES) begin
        send_line(edge_cyc);
        wait_drained();
        check_latency(2, line_start_cyc - edge_cyc);
    end

    $display("Simulation completed successfully");
    $finish;
end

endmodule

// File: list.f
line_buf_pkg.sv
line_slice.sv
line_writer.sv
line_reader.sv
line_buffer_top.sv
tb_line_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the line buffer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_line_buffer \
    -f list.f

./obj_dir/Vtb_line_buffer
